/* Makefile */
SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_axi_mem: src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module tb_axi_mem

run: obj_dir/Vtb_axi_mem
	./obj_dir/Vtb_axi_mem > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

/* rtl/axi_burst_decode.sv */
/*
 * AR and AW+W burst decode into single-beat requests
 */
module axi_burst_decode
  import axi_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  ax_chan_t   ar_i,
  input  logic       ar_valid_i,
  output logic       ar_ready_o,
  input  ax_chan_t   aw_i,
  input  logic       aw_valid_i,
  output logic       aw_ready_o,
  input  logic       w_valid_i,
  output logic       w_ready_o,

  output beat_meta_t rd_beat_o,
  output beat_meta_t wr_beat_o,
  output logic       rd_valid_o,
  output logic       wr_valid_o,
  input  logic       rd_ready_i,
  input  logic       wr_ready_i,
  output logic       rd_cnt_busy_o,
  output logic       wr_cnt_busy_o
);

  len_t       rd_cnt_d, rd_cnt_q;
  len_t       wr_cnt_d, wr_cnt_q;
  beat_meta_t rd_meta_d, rd_meta_q;
  beat_meta_t wr_meta_d, wr_meta_q;

  // first beat keeps the unaligned request address
  function automatic beat_meta_t first_beat(input ax_chan_t ax, input logic write);
    return '{
      addr:  ax.addr,
      id:    ax.id,
      last:  (ax.len == '0),
      qos:   ax.qos,
      size:  ax.size,
      write: write
    };
  endfunction

  // later beats step from the stored aligned address
  function automatic beat_meta_t next_beat(input beat_meta_t prev, input len_t cnt);
    beat_meta_t nxt;
    nxt      = prev;
    nxt.addr = prev.addr + beat_bytes(prev.size);
    nxt.last = (cnt == len_t'(1));
    return nxt;
  endfunction

  function automatic addr_t align_addr(input addr_t addr, input size_t size);
    return addr & ~(beat_bytes(size) - addr_t'(1));
  endfunction

  always_comb begin
    rd_cnt_d   = rd_cnt_q;
    rd_meta_d  = rd_meta_q;
    rd_beat_o  = rd_meta_q;
    rd_valid_o = 1'b0;
    ar_ready_o = 1'b0;
    if (rd_cnt_q != '0) begin
      rd_beat_o  = next_beat(rd_meta_q, rd_cnt_q);
      rd_valid_o = 1'b1;
      if (rd_ready_i) begin
        rd_cnt_d  = rd_cnt_q - len_t'(1);
        rd_meta_d = rd_beat_o;
      end
    end else if (ar_valid_i) begin
      rd_beat_o  = first_beat(ar_i, 1'b0);
      rd_valid_o = 1'b1;
      if (rd_ready_i) begin
        ar_ready_o     = 1'b1;
        rd_cnt_d       = ar_i.len;
        rd_meta_d      = rd_beat_o;
        rd_meta_d.addr = align_addr(ar_i.addr, ar_i.size);
      end
    end
  end

  // a write burst needs AW and its first W beat together
  always_comb begin
    wr_cnt_d   = wr_cnt_q;
    wr_meta_d  = wr_meta_q;
    wr_beat_o  = wr_meta_q;
    wr_valid_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    if (wr_cnt_q != '0) begin
      wr_beat_o  = next_beat(wr_meta_q, wr_cnt_q);
      wr_valid_o = w_valid_i;
      if (w_valid_i && wr_ready_i) begin
        w_ready_o = 1'b1;
        wr_cnt_d  = wr_cnt_q - len_t'(1);
        wr_meta_d = wr_beat_o;
      end
    end else if (aw_valid_i && w_valid_i) begin
      wr_beat_o  = first_beat(aw_i, 1'b1);
      wr_valid_o = 1'b1;
      if (wr_ready_i) begin
        aw_ready_o     = 1'b1;
        w_ready_o      = 1'b1;
        wr_cnt_d       = aw_i.len;
        wr_meta_d      = wr_beat_o;
        wr_meta_d.addr = align_addr(aw_i.addr, aw_i.size);
      end
    end
  end

  assign rd_cnt_busy_o = (rd_cnt_q != '0);
  assign wr_cnt_busy_o = (wr_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else begin
      rd_cnt_q <= rd_cnt_d;
      wr_cnt_q <= wr_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_meta_q <= rd_meta_d;
    wr_meta_q <= wr_meta_d;
  end

endmodule

/* rtl/axi_mem_pkg.sv */
/*
 * widths, constants and channel types for the AXI to banked memory bridge
 * plus the burst byte increment helper
 */
package axi_mem_pkg;

  localparam int unsigned ADDR_W      = 16;
  localparam int unsigned DATA_W      = 64;
  localparam int unsigned STRB_W      = DATA_W / 8;
  localparam int unsigned ID_W        = 4;
  localparam int unsigned NUM_BANKS   = 2;
  localparam int unsigned BANK_W      = DATA_W / NUM_BANKS;
  localparam int unsigned BANK_STRB_W = BANK_W / 8;
  localparam int unsigned META_DEPTH  = 4;

  // byte offset bits inside one full-width beat
  localparam int unsigned BEAT_LSB   = $clog2(STRB_W);
  localparam int unsigned META_PTR_W = $clog2(META_DEPTH);
  localparam int unsigned META_CNT_W = $clog2(META_DEPTH + 1);

  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [STRB_W-1:0]      strb_t;
  typedef logic [ID_W-1:0]        id_t;
  typedef logic [7:0]             len_t;
  typedef logic [2:0]             size_t;
  typedef logic [3:0]             qos_t;
  typedef logic [BANK_W-1:0]      bank_data_t;
  typedef logic [BANK_STRB_W-1:0] bank_strb_t;

  // arbiter side selection
  typedef enum logic {
    SEL_RD = 1'b0,
    SEL_WR = 1'b1
  } sel_e;

  typedef struct packed {
    id_t        id;
    addr_t      addr;
    len_t       len;
    size_t      size;
    qos_t       qos;
    logic [1:0] burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t id;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    qos_t  qos;
    size_t size;
    logic  write;
  } beat_meta_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  function automatic addr_t beat_bytes(input size_t size);
    return addr_t'(1) << size;
  endfunction

endpackage

/* rtl/axi_mem_top.sv */
/*
 * AXI4 slave to two-bank memory bridge top level
 */
module axi_mem_top
  import axi_mem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  ax_chan_t                   ar_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  ax_chan_t                   aw_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  w_chan_t                    w_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output r_chan_t                    r_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output b_chan_t                    b_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,

  output logic       [NUM_BANKS-1:0] bank_req_o,
  input  logic       [NUM_BANKS-1:0] bank_gnt_i,
  output bank_req_t  [NUM_BANKS-1:0] bank_o,
  input  logic       [NUM_BANKS-1:0] bank_rvalid_i,
  input  bank_data_t [NUM_BANKS-1:0] bank_rdata_i
);

  beat_meta_t rd_beat, wr_beat, beat_meta;
  logic       rd_valid, wr_valid, rd_ready, wr_ready;
  logic       rd_cnt_busy, wr_cnt_busy;
  mem_req_t   mem_req;
  logic       beat_take, split_gnt, meta_ready;
  data_t      rdata;
  logic       rvalid, resp_take;

  axi_burst_decode i_decode (
    .clk_i,
    .rst_ni,
    .ar_i,
    .ar_valid_i,
    .ar_ready_o,
    .aw_i,
    .aw_valid_i,
    .aw_ready_o,
    .w_valid_i,
    .w_ready_o,
    .rd_beat_o     (rd_beat),
    .wr_beat_o     (wr_beat),
    .rd_valid_o    (rd_valid),
    .wr_valid_o    (wr_valid),
    .rd_ready_i    (rd_ready),
    .wr_ready_i    (wr_ready),
    .rd_cnt_busy_o (rd_cnt_busy),
    .wr_cnt_busy_o (wr_cnt_busy)
  );

  axi_rw_arbiter i_arbiter (
    .clk_i,
    .rst_ni,
    .rd_beat_i     (rd_beat),
    .wr_beat_i     (wr_beat),
    .rd_valid_i    (rd_valid),
    .wr_valid_i    (wr_valid),
    .rd_ready_o    (rd_ready),
    .wr_ready_o    (wr_ready),
    .rd_cnt_busy_i (rd_cnt_busy),
    .wr_cnt_busy_i (wr_cnt_busy),
    .w_data_i      (w_i.data),
    .w_strb_i      (w_i.strb),
    .gnt_i         (split_gnt),
    .meta_ready_i  (meta_ready),
    .mem_req_o     (mem_req),
    .req_valid_o   (),
    .beat_meta_o   (beat_meta),
    .beat_take_o   (beat_take)
  );

  mem_bank_split i_split (
    .clk_i,
    .rst_ni,
    .mem_req_i     (mem_req),
    .beat_take_i   (beat_take),
    .gnt_o         (split_gnt),
    .bank_req_o,
    .bank_gnt_i,
    .bank_o,
    .bank_rvalid_i,
    .bank_rdata_i,
    .rdata_o       (rdata),
    .rvalid_o      (rvalid),
    .resp_take_i   (resp_take)
  );

  axi_resp_compose i_result (
    .clk_i,
    .rst_ni,
    .beat_meta_i   (beat_meta),
    .beat_take_i   (beat_take),
    .meta_ready_o  (meta_ready),
    .rdata_i       (rdata),
    .rvalid_i      (rvalid),
    .resp_take_o   (resp_take),
    .r_o,
    .r_valid_o,
    .r_ready_i,
    .b_o,
    .b_valid_o,
    .b_ready_i
  );

endmodule

/* rtl/axi_resp_compose.sv */
/*
 * in-order beat metadata FIFO steering memory responses to R or B
 */
module axi_resp_compose
  import axi_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  beat_meta_t beat_meta_i,
  input  logic       beat_take_i,
  output logic       meta_ready_o,

  input  data_t      rdata_i,
  input  logic       rvalid_i,
  output logic       resp_take_o,

  output r_chan_t    r_o,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  output b_chan_t    b_o,
  output logic       b_valid_o,
  input  logic       b_ready_i
);

  beat_meta_t            fifo_q [META_DEPTH];
  logic [META_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [META_CNT_W-1:0] cnt_q;
  beat_meta_t            head;
  logic                  head_valid;

  assign head         = fifo_q[rd_ptr_q];
  assign head_valid   = (cnt_q != '0);
  assign meta_ready_o = (cnt_q < META_CNT_W'(META_DEPTH));

  // join memory response with the oldest beat
  always_comb begin
    r_valid_o   = 1'b0;
    b_valid_o   = 1'b0;
    resp_take_o = 1'b0;
    if (rvalid_i && head_valid) begin
      if (!head.write) begin
        r_valid_o   = 1'b1;
        resp_take_o = r_ready_i;
      end else if (head.last) begin
        b_valid_o   = 1'b1;
        resp_take_o = b_ready_i;
      end else begin
        // inner write beats produce no AXI response
        resp_take_o = 1'b1;
      end
    end
  end

  assign r_o = '{
    id:   head.id,
    data: rdata_i,
    last: head.last
  };
  assign b_o = '{id: head.id};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (beat_take_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (resp_take_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + META_CNT_W'(beat_take_i) - META_CNT_W'(resp_take_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_take_i) begin
      fifo_q[wr_ptr_q] <= beat_meta_i;
    end
  end

endmodule

/* rtl/axi_rw_arbiter.sv */
/*
 * read/write beat arbiter with QoS and burst rules, choice held under stall
 */
module axi_rw_arbiter
  import axi_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  beat_meta_t rd_beat_i,
  input  beat_meta_t wr_beat_i,
  input  logic       rd_valid_i,
  input  logic       wr_valid_i,
  output logic       rd_ready_o,
  output logic       wr_ready_o,
  input  logic       rd_cnt_busy_i,
  input  logic       wr_cnt_busy_i,
  input  data_t      w_data_i,
  input  strb_t      w_strb_i,

  input  logic       gnt_i,
  input  logic       meta_ready_i,
  output mem_req_t   mem_req_o,
  output logic       req_valid_o,
  output beat_meta_t beat_meta_o,
  output logic       beat_take_o
);

  sel_e sel_d, sel_q;
  logic lock_d, lock_q;

  always_comb begin
    sel_d = sel_q;
    if (lock_q) begin
      // waiting request keeps its side
      sel_d = sel_q;
    end else if (rd_valid_i && !wr_valid_i) begin
      sel_d = SEL_RD;
    end else if (wr_valid_i && !rd_valid_i) begin
      sel_d = SEL_WR;
    end else if (rd_valid_i && wr_valid_i) begin
      if (wr_beat_i.qos > rd_beat_i.qos) begin
        sel_d = SEL_WR;
      end else if (rd_beat_i.qos > wr_beat_i.qos) begin
        sel_d = SEL_RD;
      end else if (wr_beat_i.last && !rd_beat_i.last) begin
        // write bursts cannot interleave, so a lone write goes first
        sel_d = SEL_WR;
      end else if (wr_cnt_busy_i) begin
        sel_d = SEL_WR;
      end else if (rd_cnt_busy_i) begin
        sel_d = SEL_RD;
      end else begin
        sel_d = (sel_q == SEL_RD) ? SEL_WR : SEL_RD;
      end
    end
  end

  assign beat_meta_o = (sel_d == SEL_WR) ? wr_beat_i : rd_beat_i;
  assign req_valid_o = (sel_d == SEL_WR) ? wr_valid_i : rd_valid_i;

  // split and response side accept together
  assign beat_take_o = req_valid_o & gnt_i & meta_ready_i;
  assign rd_ready_o  = beat_take_o & (sel_d == SEL_RD);
  assign wr_ready_o  = beat_take_o & (sel_d == SEL_WR);
  assign lock_d      = req_valid_o & ~beat_take_o;

  assign mem_req_o = '{
    addr:  beat_meta_o.addr,
    wdata: w_data_i,
    strb:  w_strb_i,
    we:    beat_meta_o.write
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= SEL_RD;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= lock_d;
    end
  end

endmodule

/* rtl/mem_bank_split.sv */
/*
 * beat split over parallel banks with fall-through request and response
 * registers, bank read data joined back to full width
 */
module mem_bank_split
  import axi_mem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  mem_req_t                   mem_req_i,
  input  logic                       beat_take_i,
  output logic                       gnt_o,

  output logic       [NUM_BANKS-1:0] bank_req_o,
  input  logic       [NUM_BANKS-1:0] bank_gnt_i,
  output bank_req_t  [NUM_BANKS-1:0] bank_o,
  input  logic       [NUM_BANKS-1:0] bank_rvalid_i,
  input  bank_data_t [NUM_BANKS-1:0] bank_rdata_i,

  output data_t                      rdata_o,
  output logic                       rvalid_o,
  input  logic                       resp_take_i
);

  logic [NUM_BANKS-1:0] rsp_valid;
  logic                 inflight_q;
  addr_t                beat_addr;

  assign beat_addr = {mem_req_i.addr[ADDR_W-1:BEAT_LSB], {BEAT_LSB{1'b0}}};

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    bank_req_t  req_in;
    bank_req_t  req_q;
    logic       req_full_q;
    bank_data_t rsp_q;
    logic       rsp_full_q;

    assign req_in = '{
      addr:  beat_addr + addr_t'(i * BANK_STRB_W),
      wdata: mem_req_i.wdata[i*BANK_W +: BANK_W],
      strb:  mem_req_i.strb[i*BANK_STRB_W +: BANK_STRB_W],
      we:    mem_req_i.we
    };

    // request falls through when the register is empty
    assign bank_req_o[i] = req_full_q | beat_take_i;
    assign bank_o[i]     = req_full_q ? req_q : req_in;

    assign rsp_valid[i]                = rsp_full_q | bank_rvalid_i[i];
    assign rdata_o[i*BANK_W +: BANK_W] = rsp_full_q ? rsp_q : bank_rdata_i[i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_full_q <= 1'b0;
        rsp_full_q <= 1'b0;
      end else begin
        if (bank_gnt_i[i]) begin
          req_full_q <= 1'b0;
        end else if (beat_take_i) begin
          req_full_q <= 1'b1;
        end
        if (resp_take_i) begin
          rsp_full_q <= 1'b0;
        end else if (bank_rvalid_i[i]) begin
          rsp_full_q <= 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (beat_take_i && !req_full_q) begin
        req_q <= req_in;
      end
      if (bank_rvalid_i[i] && !rsp_full_q) begin
        rsp_q <= bank_rdata_i[i];
      end
    end
  end

  assign rvalid_o = &rsp_valid;

  // one beat per bank path until its response is popped, so the
  // response registers never overflow
  assign gnt_o = ~inflight_q | resp_take_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else if (beat_take_i) begin
      inflight_q <= 1'b1;
    end else if (resp_take_i) begin
      inflight_q <= 1'b0;
    end
  end

endmodule

/* src.f */
rtl/axi_mem_pkg.sv
rtl/axi_burst_decode.sv
rtl/axi_rw_arbiter.sv
rtl/mem_bank_split.sv
rtl/axi_resp_compose.sv
rtl/axi_mem_top.sv
verif/axi_mem_props.sv
verif/tb_axi_mem.sv

/* verif/axi_mem_props.sv */
/*
 * bound AXI checks: payloads stable while waiting, INCR-only bursts
 */
module tb_axi_mem_props
  import axi_mem_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input ax_chan_t ar_i,
  input logic     ar_valid_i,
  input logic     ar_ready_o,
  input ax_chan_t aw_i,
  input logic     aw_valid_i,
  input logic     aw_ready_o,
  input w_chan_t  w_i,
  input logic     w_valid_i,
  input logic     w_ready_o,
  input r_chan_t  r_o,
  input logic     r_valid_o,
  input logic     r_ready_i,
  input b_chan_t  b_o,
  input logic     b_valid_o,
  input logic     b_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // master side holds its request until accepted
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_i))
    else $error("AR dropped or changed while waiting for ready");
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_o |=> aw_valid_i && $stable(aw_i))
    else $error("AW dropped or changed while waiting for ready");
  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable(w_i))
    else $error("W dropped or changed while waiting for ready");

  // slave side responses
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R dropped or changed while waiting for ready");
  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
    else $error("B dropped or changed while waiting for ready");

  ar_incr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && ar_i.len != '0 |-> ar_i.burst == BURST_INCR)
    else $error("AR burst longer than one beat is not INCR");
  aw_incr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && aw_i.len != '0 |-> aw_i.burst == BURST_INCR)
    else $error("AW burst longer than one beat is not INCR");

endmodule

bind axi_mem_top tb_axi_mem_props i_props (.*);

/* verif/tb_axi_mem.sv */
/*
 * testbench for the AXI to two-bank memory bridge
 * random AXI master, bank memory model, byte reference model and checks
 */
module tb_axi_mem
  import axi_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES     = 16;
  localparam int CYCLES_PER_BURST = 200;
  localparam int N_SINGLE         = 8;
  localparam int N_WBURST         = 6;
  localparam int N_NARROW         = 8;
  localparam int N_RBURST         = 6;
  localparam int N_MIXED          = 24;
  localparam int TOTAL_BURSTS     = 2 * N_SINGLE + 2 * N_WBURST + 2 * N_NARROW + N_RBURST
                                    + N_MIXED;
  localparam int BANK_WORDS       = 2 ** (ADDR_W - BEAT_LSB);

  logic                       clk_i, rst_ni;
  ax_chan_t                   ar_i, aw_i;
  logic                       ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  w_chan_t                    w_i;
  logic                       w_valid_i, w_ready_o;
  r_chan_t                    r_o;
  logic                       r_valid_o, r_ready_i;
  b_chan_t                    b_o;
  logic                       b_valid_o, b_ready_i;
  logic       [NUM_BANKS-1:0] bank_req_o, bank_gnt_i, bank_rvalid_i;
  bank_req_t  [NUM_BANKS-1:0] bank_o;
  bank_data_t [NUM_BANKS-1:0] bank_rdata_i;

  logic [7:0]                 ref_mem [2 ** ADDR_W];
  bank_data_t                 bank_mem [NUM_BANKS][BANK_WORDS];
  ax_chan_t                   ar_q[$], aw_q[$];
  w_chan_t                    w_q[$];
  r_chan_t                    exp_r_q[$];
  b_chan_t                    exp_b_q[$];
  logic       [NUM_BANKS-1:0] rsp_pend;
  bank_data_t [NUM_BANKS-1:0] rsp_data;
  logic                       w_hold, backpressure;
  int                         r_errs, b_errs, other_errs;

  axi_mem_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // initial memory content from every address bit
  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr * 37) ^ 8'(addr >> 8);
  endfunction

  // later INCR beats step from the aligned start
  function automatic int beat_addr(input int addr, input int size, input int n);
    int step;
    step = 1 << size;
    if (n == 0) begin
      return addr;
    end
    return ((addr & ~(step - 1)) + n * step) & 32'hffff;
  endfunction

  function automatic data_t block_data(input int addr);
    data_t d;
    int    base;
    base = addr & ~7;
    for (int k = 0; k < STRB_W; k++) begin
      d[8*k +: 8] = ref_mem[base + k];
    end
    return d;
  endfunction

  task automatic check_r(input r_chan_t got, input r_chan_t want);
    if (got !== want) begin
      r_errs++;
      $display("Error r_o: id %h data %h last %h, expected id %h data %h last %h",
               got.id, got.data, got.last, want.id, want.data, want.last);
    end
  endtask

  task automatic check_b(input b_chan_t got, input b_chan_t want);
    if (got !== want) begin
      b_errs++;
      $display("Error b_o: id %h, expected id %h", got.id, want.id);
    end
  endtask

  task automatic read_burst(input int addr, input int len, input int size, input int qos);
    ax_chan_t ar;
    r_chan_t  want;
    ar = '{id: id_t'($urandom), addr: addr_t'(addr), len: len_t'(len),
           size: size_t'(size), qos: qos_t'(qos), burst: BURST_INCR};
    ar_q.push_back(ar);
    for (int n = 0; n <= len; n++) begin
      want.id   = ar.id;
      want.data = block_data(beat_addr(addr, size, n));
      want.last = (n == len);
      exp_r_q.push_back(want);
    end
  endtask

  task automatic write_burst(input int addr, input int len, input int size, input int qos,
                             input bit narrow);
    ax_chan_t aw;
    w_chan_t  w;
    b_chan_t  want;
    strb_t    mask;
    int       beat, lo, hi;
    aw = '{id: id_t'($urandom), addr: addr_t'(addr), len: len_t'(len),
           size: size_t'(size), qos: qos_t'(qos), burst: BURST_INCR};
    aw_q.push_back(aw);
    for (int n = 0; n <= len; n++) begin
      beat = beat_addr(addr, size, n);
      // byte lanes of this beat on the 64-bit bus
      lo = beat & 7;
      hi = (lo & ~((1 << size) - 1)) + (1 << size);
      for (int k = 0; k < STRB_W; k++) begin
        mask[k] = (k >= lo) && (k < hi);
      end
      w.data = {$urandom, $urandom};
      w.strb = narrow ? (strb_t'($urandom) & mask) : mask;
      w.last = (n == len);
      for (int k = 0; k < STRB_W; k++) begin
        if (w.strb[k]) begin
          ref_mem[(beat & ~7) + k] = w.data[8*k +: 8];
        end
      end
      w_q.push_back(w);
    end
    want.id = aw.id;
    exp_b_q.push_back(want);
  endtask

  task automatic wait_idle();
    while (ar_q.size() != 0 || aw_q.size() != 0 || w_q.size() != 0 ||
           exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
  endtask

  // granted bank request gets its answer on the next cycle
  task automatic bank_access(input int b);
    bank_req_t req;
    int        idx;
    req = bank_o[b];
    idx = int'(req.addr) >> BEAT_LSB;
    if (req.addr[2:0] != 3'(b * BANK_STRB_W)) begin
      other_errs++;
      $display("Error bank_o[%0d].addr: got %h, low bits expected %h",
               b, req.addr, 3'(b * BANK_STRB_W));
    end
    if (req.we) begin
      for (int k = 0; k < BANK_STRB_W; k++) begin
        if (req.strb[k]) begin
          bank_mem[b][idx][8*k +: 8] = req.wdata[8*k +: 8];
        end
      end
    end
    rsp_data[b] = bank_mem[b][idx];
    rsp_pend[b] = 1'b1;
  endtask

  // AXI master and bank model driven on the falling edge
  initial begin
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      ar_valid_i = (ar_q.size() != 0);
      if (ar_valid_i) begin
        ar_i = ar_q[0];
      end
      aw_valid_i = (aw_q.size() != 0);
      if (aw_valid_i) begin
        aw_i = aw_q[0];
      end
      // W may pause between beats but holds once offered
      w_valid_i = (w_q.size() != 0) && (w_hold || ($urandom % 4 != 0));
      if (w_q.size() != 0) begin
        w_i = w_q[0];
      end
      r_ready_i = !backpressure || ($urandom % 2 == 0);
      b_ready_i = !backpressure || ($urandom % 3 != 0);
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_rvalid_i[b] = rsp_pend[b];
        bank_rdata_i[b]  = rsp_data[b];
        bank_gnt_i[b]    = ($urandom % 3 != 0);
      end
      rsp_pend = '0;
      // transfers that happen at the next rising edge
      #1;
      if (ar_valid_i && ar_ready_o) begin
        void'(ar_q.pop_front());
      end
      if (aw_valid_i && aw_ready_o) begin
        void'(aw_q.pop_front());
      end
      w_hold = w_valid_i && !w_ready_o;
      if (w_valid_i && w_ready_o) begin
        void'(w_q.pop_front());
      end
      if (r_valid_o && r_ready_i) begin
        if (exp_r_q.size() == 0) begin
          other_errs++;
          $display("an R beat with id %h arrived while no read beat was expected", r_o.id);
        end else begin
          check_r(r_o, exp_r_q.pop_front());
        end
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          other_errs++;
          $display("a B response with id %h arrived while no write was expected", b_o.id);
        end else begin
          check_b(b_o, exp_b_q.pop_front());
        end
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (bank_req_o[b] && bank_gnt_i[b]) begin
          bank_access(b);
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + CYCLES_PER_BURST * TOTAL_BURSTS) @(posedge clk_i);
    $display("timeout: responses still missing after %0d bursts worth of cycles",
             TOTAL_BURSTS);
    $display("errors: r %0d, b %0d, other %0d", r_errs, b_errs, other_errs);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int addr, len, size;
    int addrs[$];
    int lens[$];
    void'($urandom(32'h7c51));
    rst_ni        = 1'b0;
    ar_i          = '0;
    ar_valid_i    = 1'b0;
    aw_i          = '0;
    aw_valid_i    = 1'b0;
    w_i           = '0;
    w_valid_i     = 1'b0;
    r_ready_i     = 1'b0;
    b_ready_i     = 1'b0;
    bank_gnt_i    = '0;
    bank_rvalid_i = '0;
    bank_rdata_i  = '0;
    rsp_pend      = '0;
    rsp_data      = '0;
    w_hold        = 1'b0;
    backpressure  = 1'b0;
    r_errs        = 0;
    b_errs        = 0;
    other_errs    = 0;
    for (int a = 0; a < 2 ** ADDR_W; a++) begin
      ref_mem[a] = fill_byte(a);
      bank_mem[(a >> 2) & 1][a >> BEAT_LSB][8*(a & 3) +: 8] = fill_byte(a);
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);

    // single full-width writes then read back
    for (int i = 0; i < N_SINGLE; i++) begin
      addr = ($urandom % 32'h1000) & ~7;
      addrs.push_back(addr);
      write_burst(addr, 0, 3, 0, 1'b0);
    end
    wait_idle();
    foreach (addrs[i]) read_burst(addrs[i], 0, 3, 0);
    wait_idle();

    // write bursts read back as bursts of the same shape
    addrs.delete();
    for (int i = 0; i < N_WBURST; i++) begin
      addr = 32'h1000 + (($urandom % 32'h0f00) & ~7);
      len  = $urandom % 8;
      addrs.push_back(addr);
      lens.push_back(len);
      write_burst(addr, len, 3, 0, 1'b0);
    end
    wait_idle();
    foreach (addrs[i]) read_burst(addrs[i], lens[i], 3, 0);
    wait_idle();

    // narrow strobed writes with full-width read-back of the touched words
    addrs.delete();
    for (int i = 0; i < N_NARROW; i++) begin
      size = $urandom % 3;
      len  = $urandom % 4;
      addr = 32'h2000 + (($urandom % 32'h0f00) & ~((1 << size) - 1));
      addrs.push_back(addr);
      write_burst(addr, len, size, 0, 1'b1);
    end
    wait_idle();
    foreach (addrs[i]) read_burst(addrs[i] & ~7, 2, 3, 0);
    wait_idle();

    // read bursts of any size from unaligned starts
    for (int i = 0; i < N_RBURST; i++) begin
      read_burst($urandom % 32'h3000, $urandom % 8, $urandom % 4, 0);
    end
    wait_idle();

    // mixed traffic with reads in the low half and writes in the high half
    backpressure = 1'b1;
    for (int i = 0; i < N_MIXED; i++) begin
      size = $urandom % 4;
      len  = $urandom % 8;
      addr = ($urandom % 32'h7f00) & ~((1 << size) - 1);
      if ($urandom % 2 == 0) begin
        read_burst(addr, len, size, $urandom % 16);
      end else begin
        write_burst(32'h8000 + addr, len, size, $urandom % 16, 1'b1);
      end
      repeat ($urandom % 4) @(posedge clk_i);
    end
    wait_idle();
    backpressure = 1'b0;

    $display("errors: r %0d, b %0d, other %0d", r_errs, b_errs, other_errs);
    if (r_errs + b_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
